/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_accel_ctrl
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_accel_ctrl.sv */
`timescale 1ns/1ps

module tb_accel_ctrl;

    logic        clk;
    logic        rst_n;
    logic [31:0] h2f_io;
    logic        h2f_write;

    logic        rf_ram_sel;
    logic [4:0]  sdram_read_sel;
    logic        sdram_rd;
    logic        sdram_wr;
    logic [14:0] sdram_line;
    logic [9:0]  ldst_rf_line;
    logic        rf_copy;
    logic [9:0]  rf_rd_addr;
    logic [9:0]  rf_wr_addr;
    logic [31:0] eu_fetch;
    logic [31:0] eu_exec;
    logic [3:0]  eu_sub_idx;
    logic [19:0] eu_fetch_addr;
    logic        done;

    // stimulus and expected values per row
    logic [31:0] tab_word[$];
    int          tab_poke[$];
    logic        tab_ram[$];
    logic [4:0]  tab_rsel[$];
    logic [31:0] tab_fmask[$];
    logic [31:0] tab_xmask[$];
    int          tab_kind[$];
    int          tab_lines[$];
    int          tab_a[$];
    int          tab_b[$];
    int          tab_sa[$];
    int          tab_sb[$];

    logic        model_ram;
    logic [15:0] lfsr;
    bit          table_ready;
    int          err_cnt;
    int          n_checks;
    int          n_fail;
    int          cur_test;
    int          cur_k;

    accel_ctrl_top i_accel_ctrl_top (
        .clk(clk), .rst_n(rst_n), .h2f_io(h2f_io), .h2f_write(h2f_write),
        .rf_ram_sel(rf_ram_sel), .sdram_read_sel(sdram_read_sel),
        .sdram_rd(sdram_rd), .sdram_wr(sdram_wr), .sdram_line(sdram_line),
        .ldst_rf_line(ldst_rf_line), .rf_copy(rf_copy),
        .rf_rd_addr(rf_rd_addr), .rf_wr_addr(rf_wr_addr),
        .eu_fetch(eu_fetch), .eu_exec(eu_exec), .eu_sub_idx(eu_sub_idx),
        .eu_fetch_addr(eu_fetch_addr), .done(done)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // 16-bit Fibonacci LFSR on taps 16 14 13 11
    // one step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_ldst(input logic [2:0] op, input logic [3:0] lines,
                                             input logic [9:0] rf, input logic [14:0] sd);
        return {op, lines, rf, sd};
    endfunction

    function automatic logic [31:0] enc_move(input logic [3:0] lines, input logic [9:0] src,
                                             input logic [9:0] dst, input logic sfrz,
                                             input logic dfrz);
        return {3'd2, lines, src, dst, sfrz, dfrz, 3'b000};
    endfunction

    function automatic logic [31:0] enc_eu(input logic [2:0] op, input logic [4:0] grp,
                                           input logic [3:0] sub, input logic [19:0] faddr);
        return {op, grp, sub, faddr};
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        n_checks++;
        assert (got === exp)
        else begin
            $display("ERR %0t: test %0d cycle %0d %s is %h, expected %h",
                     $time, cur_test, cur_k, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_eq(what, 32'(got), 32'(exp));
    endtask

    // expectations straight from the field layout
    task automatic add_row(input logic [31:0] w, input int poke);
        logic [2:0] op;
        logic [4:0] grp;
        int         kind;
        op   = w[31:29];
        grp  = w[28:24];
        kind = (op <= 3'd2) ? int'(op) + 1 : 0;
        if (kind == 1 || kind == 2)
            model_ram = 1'b1;
        else if (kind == 3)
            model_ram = 1'b0;
        tab_word.push_back(w);
        tab_poke.push_back(poke);
        tab_ram.push_back(model_ram);
        tab_rsel.push_back(grp);
        tab_fmask.push_back(op == 3'd3 ? 32'd1 << grp : 32'd0);
        tab_xmask.push_back(op == 3'd4 ? 32'd1 << grp : 32'd0);
        tab_kind.push_back(kind);
        tab_lines.push_back(int'(w[28:25]));
        if (kind == 3) begin
            tab_a.push_back(int'(w[24:15]));
            tab_b.push_back(int'(w[14:5]));
            tab_sa.push_back(int'(!w[4]));
            tab_sb.push_back(int'(!w[3]));
        end else begin
            tab_a.push_back(int'(w[14:0]));
            tab_b.push_back(int'(w[24:15]));
            tab_sa.push_back(1);
            tab_sb.push_back(1);
        end
    endtask

    //////////////////////////////////////////////////
    // one table entry
    //////////////////////////////////////////////////

    task automatic run_entry(input int i);
        logic [31:0] w;
        logic        prev_ram;
        logic [4:0]  prev_rsel;
        logic        act;
        int          k;
        int          idx;
        int          done_k;
        int          n_rd;
        int          n_wr;
        int          n_cp;
        int          errs_before;
        w           = tab_word[i];
        errs_before = err_cnt;
        n_rd        = 0;
        n_wr        = 0;
        n_cp        = 0;
        cur_test    = i + 1;
        done_k      = (tab_kind[i] != 0) ? tab_lines[i] + 4 : 3;
        // selects left behind by the previous row, reset values for the first
        prev_ram    = (i == 0) ? 1'b0 : tab_ram[i - 1];
        prev_rsel   = (i == 0) ? 5'd0 : tab_rsel[i - 1];
        @(negedge clk);
        h2f_io    = w;
        h2f_write = 1'b1;
        for (k = 1; k <= 40; k++) begin
            @(negedge clk);
            cur_k = k;
            // host bus moves on after the write
            // extra write only in the poke cycle
            h2f_io    = ~w;
            h2f_write = (k == tab_poke[i]);
            if (k == 1) begin
                check_bit("rf_ram_sel", rf_ram_sel, prev_ram);
                check_eq("sdram_read_sel", 32'(sdram_read_sel), 32'(prev_rsel));
            end else begin
                check_bit("rf_ram_sel", rf_ram_sel, tab_ram[i]);
                check_eq("sdram_read_sel", 32'(sdram_read_sel), 32'(tab_rsel[i]));
            end
            check_eq("eu_fetch", eu_fetch, (k == 2) ? tab_fmask[i] : 32'd0);
            check_eq("eu_exec", eu_exec, (k == 2) ? tab_xmask[i] : 32'd0);
            check_eq("eu_sub_idx", 32'(eu_sub_idx), 32'(w[23:20]));
            check_eq("eu_fetch_addr", 32'(eu_fetch_addr), 32'(w[19:0]));
            idx = k - 3;
            act = (k >= 3) && (idx <= tab_lines[i]);
            check_bit("sdram_rd", sdram_rd, act && tab_kind[i] == 1);
            check_bit("sdram_wr", sdram_wr, act && tab_kind[i] == 2);
            check_bit("rf_copy", rf_copy, act && tab_kind[i] == 3);
            if ((sdram_rd || sdram_wr) && k >= 3) begin
                check_eq("sdram_line", 32'(sdram_line), (tab_a[i] + idx) % 32768);
                check_eq("ldst_rf_line", 32'(ldst_rf_line), (tab_b[i] + idx) % 1024);
            end
            if (rf_copy && k >= 3) begin
                check_eq("rf_rd_addr", 32'(rf_rd_addr), (tab_a[i] + tab_sa[i] * idx) % 1024);
                check_eq("rf_wr_addr", 32'(rf_wr_addr), (tab_b[i] + tab_sb[i] * idx) % 1024);
            end
            if (sdram_rd)
                n_rd++;
            if (sdram_wr)
                n_wr++;
            if (rf_copy)
                n_cp++;
            check_bit("done", done, k >= done_k);
            if (done)
                break;
        end
        h2f_write = 1'b0;
        if (k > 40) begin
            $display("test %0d: done never came back high", cur_test);
            err_cnt++;
        end else begin
            check_eq("done cycle", k, done_k);
        end
        check_eq("load lines", n_rd, (tab_kind[i] == 1) ? tab_lines[i] + 1 : 0);
        check_eq("store lines", n_wr, (tab_kind[i] == 2) ? tab_lines[i] + 1 : 0);
        check_eq("move lines", n_cp, (tab_kind[i] == 3) ? tab_lines[i] + 1 : 0);
        if (err_cnt == errs_before) begin
            $display("test %0d op %0d word %h: ok", cur_test, w[31:29], w);
        end else begin
            $display("test %0d op %0d word %h: mismatch", cur_test, w[31:29], w);
            n_fail++;
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] r_op;
        logic [31:0] r_rest;
        logic [31:0] r_poke;
        rst_n     = 1'b0;
        h2f_io    = '0;
        h2f_write = 1'b0;
        err_cnt   = 0;
        n_checks  = 0;
        n_fail    = 0;
        cur_test  = 0;
        cur_k     = 0;
        model_ram = 1'b0;
        lfsr      = 16'd26406;

        // directed rows
        add_row(enc_eu(3'd3, 5'd7, 4'h9, 20'h12345), 0);
        add_row(enc_eu(3'd4, 5'd31, 4'h2, 20'habcde), 1);
        add_row(enc_ldst(3'd0, 4'd3, 10'h3fe, 15'h7ffe), 4);
        add_row(enc_ldst(3'd1, 4'd0, 10'h055, 15'h0123), 0);
        add_row(enc_move(4'd2, 10'h010, 10'h200, 1'b0, 1'b0), 0);
        add_row(enc_move(4'd5, 10'h3ff, 10'h020, 1'b1, 1'b0), 3);
        add_row(enc_move(4'd1, 10'h100, 10'h3ff, 1'b0, 1'b1), 0);
        add_row(enc_ldst(3'd1, 4'd15, 10'h200, 15'h4000), 9);
        add_row({3'd6, 29'h0abcdef}, 0);
        add_row({3'd7, 29'h1f00ff0}, 1);
        add_row(enc_eu(3'd3, 5'd0, 4'hf, 20'h00001), 0);

        // random rows
        for (int n = 0; n < 12; n++) begin
            r_op   = rand_bits(3);
            r_rest = rand_bits(29);
            r_poke = rand_bits(1);
            add_row({r_op[2:0], r_rest[28:0]}, int'(r_poke[0]));
        end
        table_ready = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_bit("done after reset", done, 1'b1);
        check_bit("rf_ram_sel after reset", rf_ram_sel, 1'b0);
        check_eq("sdram_read_sel after reset", 32'(sdram_read_sel), 32'd0);
        check_eq("eu_fetch after reset", eu_fetch, 32'd0);
        check_eq("eu_exec after reset", eu_exec, 32'd0);
        check_bit("sdram_rd after reset", sdram_rd, 1'b0);
        check_bit("sdram_wr after reset", sdram_wr, 1'b0);
        check_bit("rf_copy after reset", rf_copy, 1'b0);
        if (err_cnt == 0) begin
            $display("test 0 reset values: ok");
        end else begin
            $display("test 0 reset values: mismatch");
            n_fail++;
        end

        for (int i = 0; i < tab_word.size(); i++)
            run_entry(i);

        $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tab_word.size() + 1, n_fail, n_checks, err_cnt);
        if (err_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // 40 cycles per row plus room for reset
    initial begin
        wait (table_ready);
        repeat (tab_word.size() * 40 + 20) @(posedge clk);
        $display("timeout: the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* sources.f */
src/accel_pkg.sv
src/isa_pkg.sv
src/inst_decode.sv
src/ctrl_unit.sv
src/rf_ldst_unit.sv
src/rf_move_unit.sv
src/accel_ctrl_top.sv
bench/tb_accel_ctrl.sv

/* src/accel_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module accel_ctrl_top
    import accel_pkg::*;
    import isa_pkg::*;
#(
    parameter int RF_ADDR_W = RF_ADDR_W_DEF
) (
    input  logic        clk,
    input  logic        rst_n,

    // host IO register
    input  inst_t       h2f_io,
    input  logic        h2f_write,

    // register file and SDRAM side
    output logic        rf_ram_sel,
    output group_idx_t  sdram_read_sel,
    output logic        sdram_rd,
    output logic        sdram_wr,
    output sdram_addr_t sdram_line,
    output rf_addr_t    ldst_rf_line,
    output logic        rf_copy,
    output rf_addr_t    rf_rd_addr,
    output rf_addr_t    rf_wr_addr,

    // execution-unit groups
    output group_mask_t eu_fetch,
    output group_mask_t eu_exec,
    output sub_idx_t    eu_sub_idx,
    output fetch_addr_t eu_fetch_addr,

    output logic        done
);

    inst_t       inst_q;
    logic        load, store, move, fetch, exec;
    rf_addr_t    ldst_rf_addr;
    sdram_addr_t ldst_sdram_addr;
    line_cnt_t   ldst_line_num;
    rf_addr_t    move_src_addr, move_dst_addr;
    line_cnt_t   move_line_num;
    logic        move_src_freeze, move_dst_freeze;
    group_idx_t  eu_group_idx;
    logic        ldst_load_start, ldst_store_start, move_start;
    logic        ldst_busy, move_busy;

    inst_decode #(.RF_ADDR_W(RF_ADDR_W)) i_inst_decode (
        .inst(inst_q), .load(load), .store(store), .move(move),
        .fetch(fetch), .exec(exec),
        .ldst_rf_addr(ldst_rf_addr), .ldst_sdram_addr(ldst_sdram_addr),
        .ldst_line_num(ldst_line_num),
        .move_src_addr(move_src_addr), .move_dst_addr(move_dst_addr),
        .move_line_num(move_line_num), .move_src_freeze(move_src_freeze),
        .move_dst_freeze(move_dst_freeze),
        .eu_group_idx(eu_group_idx), .eu_sub_idx(eu_sub_idx),
        .eu_fetch_addr(eu_fetch_addr)
    );

    ctrl_unit i_ctrl_unit (
        .clk(clk), .rst_n(rst_n), .h2f_io(h2f_io), .h2f_write(h2f_write),
        .load(load), .store(store), .move(move), .fetch(fetch), .exec(exec),
        .eu_group_idx(eu_group_idx), .ldst_busy(ldst_busy), .move_busy(move_busy),
        .inst_q(inst_q), .ldst_load_start(ldst_load_start),
        .ldst_store_start(ldst_store_start), .move_start(move_start),
        .rf_ram_sel(rf_ram_sel), .sdram_read_sel(sdram_read_sel),
        .eu_fetch(eu_fetch), .eu_exec(eu_exec), .done(done)
    );

    rf_ldst_unit #(.RF_ADDR_W(RF_ADDR_W)) i_rf_ldst_unit (
        .clk(clk), .rst_n(rst_n),
        .load_start(ldst_load_start), .store_start(ldst_store_start),
        .rf_addr(ldst_rf_addr), .sdram_addr(ldst_sdram_addr),
        .line_num(ldst_line_num), .busy(ldst_busy), .rf_line(ldst_rf_line),
        .sdram_line(sdram_line), .sdram_rd(sdram_rd), .sdram_wr(sdram_wr)
    );

    rf_move_unit #(.RF_ADDR_W(RF_ADDR_W)) i_rf_move_unit (
        .clk(clk), .rst_n(rst_n), .start(move_start),
        .src_addr(move_src_addr), .dst_addr(move_dst_addr),
        .line_num(move_line_num), .src_freeze(move_src_freeze),
        .dst_freeze(move_dst_freeze), .busy(move_busy),
        .rf_rd_addr(rf_rd_addr), .rf_wr_addr(rf_wr_addr), .rf_copy(rf_copy)
    );

endmodule

`default_nettype wire

/* src/accel_pkg.sv */
package accel_pkg;

    //////////////////////////////////////////////////
    // datapath widths
    //////////////////////////////////////////////////

    // rf address field width, also the default for RF_ADDR_W
    localparam int RF_ADDR_W_DEF = 10;
    localparam int SDRAM_ADDR_W  = 15;
    localparam int LINE_CNT_W    = 4;
    localparam int GROUP_IDX_W   = 5;
    localparam int SUB_IDX_W     = 4;
    localparam int FETCH_ADDR_W  = 20;
    localparam int NUM_GROUPS    = 32;

    //////////////////////////////////////////////////
    // datapath types
    //////////////////////////////////////////////////

    // register-file line address
    typedef logic [RF_ADDR_W_DEF-1:0] rf_addr_t;
    typedef logic [SDRAM_ADDR_W-1:0]  sdram_addr_t;

    // field value n means n+1 lines
    typedef logic [LINE_CNT_W-1:0]    line_cnt_t;

    // execution-unit addressing
    typedef logic [GROUP_IDX_W-1:0]   group_idx_t;
    typedef logic [SUB_IDX_W-1:0]     sub_idx_t;
    typedef logic [FETCH_ADDR_W-1:0]  fetch_addr_t;
    typedef logic [NUM_GROUPS-1:0]    group_mask_t;

endpackage

/* src/ctrl_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_unit
    import accel_pkg::*;
    import isa_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // host register
    input  inst_t       h2f_io,
    input  logic        h2f_write,

    // decoded instruction
    input  logic        load,
    input  logic        store,
    input  logic        move,
    input  logic        fetch,
    input  logic        exec,
    input  group_idx_t  eu_group_idx,

    input  logic        ldst_busy,
    input  logic        move_busy,

    output inst_t       inst_q,
    output logic        ldst_load_start,
    output logic        ldst_store_start,
    output logic        move_start,
    output logic        rf_ram_sel,
    output group_idx_t  sdram_read_sel,
    output group_mask_t eu_fetch,
    output group_mask_t eu_exec,
    output logic        done
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        accept;
    logic        sel_set_ldst;
    logic        sel_clr_move;
    group_mask_t group_onehot;

    // idle and no sequencer running
    assign done   = (state == IDLE) && !ldst_busy && !move_busy;
    assign accept = h2f_write && done;

    // hold the word so the host bus may change afterwards
    always_ff @(posedge clk) begin
        if (accept)
            inst_q <= h2f_io;
    end

    //////////////////////////////////////////////////
    // select registers
    //////////////////////////////////////////////////

    assign sel_clr_move = (state == DECODE) && move;
    assign sel_set_ldst = (state == DECODE) && (load || store);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rf_ram_sel     <= 1'b0;
            sdram_read_sel <= '0;
        end else begin
            // move wins over load/store
            if (sel_clr_move)
                rf_ram_sel <= 1'b0;
            else if (sel_set_ldst)
                rf_ram_sel <= 1'b1;
            if (state == DECODE)
                sdram_read_sel <= eu_group_idx;
        end
    end

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    assign group_onehot = group_mask_t'(1) << eu_group_idx;

    always_comb begin
        state_nxt        = state;
        ldst_load_start  = 1'b0;
        ldst_store_start = 1'b0;
        move_start       = 1'b0;
        eu_fetch         = '0;
        eu_exec          = '0;
        case (state)
            IDLE: begin
                if (accept)
                    state_nxt = DECODE;
            end
            DECODE: state_nxt = ISSUE;
            default: begin
                // single-cycle issue strobes
                ldst_load_start  = load;
                ldst_store_start = store;
                move_start       = move;
                if (fetch)
                    eu_fetch = group_onehot;
                if (exec)
                    eu_exec = group_onehot;
                state_nxt = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode
    import accel_pkg::*;
    import isa_pkg::*;
#(
    parameter int RF_ADDR_W = RF_ADDR_W_DEF
) (
    input  inst_t       inst,

    output logic        load,
    output logic        store,
    output logic        move,
    output logic        fetch,
    output logic        exec,

    output rf_addr_t    ldst_rf_addr,
    output sdram_addr_t ldst_sdram_addr,
    output line_cnt_t   ldst_line_num,

    output rf_addr_t    move_src_addr,
    output rf_addr_t    move_dst_addr,
    output line_cnt_t   move_line_num,
    output logic        move_src_freeze,
    output logic        move_dst_freeze,

    output group_idx_t  eu_group_idx,
    output sub_idx_t    eu_sub_idx,
    output fetch_addr_t eu_fetch_addr
);

    opcode_t opcode;

    assign opcode = opcode_t'(inst[OPC_MSB:OPC_LSB]);

    // one flag per known opcode, none otherwise
    always_comb begin
        load  = 1'b0;
        store = 1'b0;
        move  = 1'b0;
        fetch = 1'b0;
        exec  = 1'b0;
        case (opcode)
            OP_LOAD:  load  = 1'b1;
            OP_STORE: store = 1'b1;
            OP_MOVE:  move  = 1'b1;
            OP_FETCH: fetch = 1'b1;
            OP_EXEC:  exec  = 1'b1;
            default:  ;
        endcase
    end

    //////////////////////////////////////////////////
    // operand fields
    //////////////////////////////////////////////////

    // narrow rf builds keep the low bits of the 10-bit field
    assign ldst_rf_addr    = rf_addr_t'(inst[LS_RF_LSB +: RF_ADDR_W]);
    assign ldst_sdram_addr = inst[LS_SD_MSB:LS_SD_LSB];
    assign ldst_line_num   = inst[LS_LINES_MSB:LS_LINES_LSB];

    assign move_src_addr   = rf_addr_t'(inst[MV_SRC_LSB +: RF_ADDR_W]);
    assign move_dst_addr   = rf_addr_t'(inst[MV_DST_LSB +: RF_ADDR_W]);
    assign move_line_num   = inst[MV_LINES_MSB:MV_LINES_LSB];
    assign move_src_freeze = inst[MV_SRC_FRZ];
    assign move_dst_freeze = inst[MV_DST_FRZ];

    assign eu_group_idx    = inst[EU_GRP_MSB:EU_GRP_LSB];
    assign eu_sub_idx      = inst[EU_SUB_MSB:EU_SUB_LSB];
    assign eu_fetch_addr   = inst[EU_FADDR_MSB:EU_FADDR_LSB];

endmodule

`default_nettype wire

/* src/isa_pkg.sv */
package isa_pkg;

    //////////////////////////////////////////////////
    // instruction word
    //////////////////////////////////////////////////

    localparam int INST_W = 32;
    typedef logic [INST_W-1:0] inst_t;

    // opcode in the top three bits
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 29;

    // unlisted codes decode as no-operation
    typedef enum logic [OPC_MSB-OPC_LSB:0] {
        OP_LOAD  = 3'd0,
        OP_STORE = 3'd1,
        OP_MOVE  = 3'd2,
        OP_FETCH = 3'd3,
        OP_EXEC  = 3'd4
    } opcode_t;

    //////////////////////////////////////////////////
    // field positions
    //////////////////////////////////////////////////

    // load / store
    localparam int LS_LINES_MSB = 28;
    localparam int LS_LINES_LSB = 25;
    localparam int LS_RF_LSB    = 15;
    localparam int LS_SD_MSB    = 14;
    localparam int LS_SD_LSB    = 0;

    // move
    localparam int MV_LINES_MSB = 28;
    localparam int MV_LINES_LSB = 25;
    localparam int MV_SRC_LSB   = 15;
    localparam int MV_DST_LSB   = 5;
    localparam int MV_SRC_FRZ   = 4;
    localparam int MV_DST_FRZ   = 3;

    // fetch / exec
    localparam int EU_GRP_MSB   = 28;
    localparam int EU_GRP_LSB   = 24;
    localparam int EU_SUB_MSB   = 23;
    localparam int EU_SUB_LSB   = 20;
    localparam int EU_FADDR_MSB = 19;
    localparam int EU_FADDR_LSB = 0;

    // control FSM
    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        ISSUE
    } ctrl_state_t;

endpackage

/* src/rf_ldst_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rf_ldst_unit
    import accel_pkg::*;
#(
    parameter int RF_ADDR_W = RF_ADDR_W_DEF
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        load_start,
    input  logic        store_start,
    input  rf_addr_t    rf_addr,
    input  sdram_addr_t sdram_addr,
    input  line_cnt_t   line_num,

    output logic        busy,
    output rf_addr_t    rf_line,
    output sdram_addr_t sdram_line,
    output logic        sdram_rd,
    output logic        sdram_wr
);

    logic                 start;
    logic                 is_load;
    line_cnt_t            lines_left;
    logic [RF_ADDR_W-1:0] rf_cur;
    sdram_addr_t          sd_cur;

    assign start = load_start || store_start;

    //////////////////////////////////////////////////
    // line counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            lines_left <= '0;
        end else if (start) begin
            busy       <= 1'b1;
            lines_left <= line_num;
        end else if (busy) begin
            // last line leaves busy
            if (lines_left == '0)
                busy <= 1'b0;
            else
                lines_left <= lines_left - 1'b1;
        end
    end

    // operands and running addresses
    always_ff @(posedge clk) begin
        if (start) begin
            is_load <= load_start;
            rf_cur  <= rf_addr[RF_ADDR_W-1:0];
            sd_cur  <= sdram_addr;
        end else if (busy) begin
            rf_cur <= rf_cur + 1'b1;
            sd_cur <= sd_cur + 1'b1;
        end
    end

    assign rf_line    = rf_addr_t'(rf_cur);
    assign sdram_line = sd_cur;
    assign sdram_rd   = busy && is_load;
    assign sdram_wr   = busy && !is_load;

endmodule

`default_nettype wire

/* src/rf_move_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rf_move_unit
    import accel_pkg::*;
#(
    parameter int RF_ADDR_W = RF_ADDR_W_DEF
) (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      start,
    input  rf_addr_t  src_addr,
    input  rf_addr_t  dst_addr,
    input  line_cnt_t line_num,
    input  logic      src_freeze,
    input  logic      dst_freeze,

    output logic      busy,
    output rf_addr_t  rf_rd_addr,
    output rf_addr_t  rf_wr_addr,
    output logic      rf_copy
);

    line_cnt_t            lines_left;
    logic                 src_frz_q;
    logic                 dst_frz_q;
    logic [RF_ADDR_W-1:0] rd_cur;
    logic [RF_ADDR_W-1:0] wr_cur;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            lines_left <= '0;
        end else if (start) begin
            busy       <= 1'b1;
            lines_left <= line_num;
        end else if (busy) begin
            if (lines_left == '0)
                busy <= 1'b0;
            else
                lines_left <= lines_left - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // address stepping
    //////////////////////////////////////////////////

    // a frozen side keeps repeating its first address
    always_ff @(posedge clk) begin
        if (start) begin
            src_frz_q <= src_freeze;
            dst_frz_q <= dst_freeze;
            rd_cur    <= src_addr[RF_ADDR_W-1:0];
            wr_cur    <= dst_addr[RF_ADDR_W-1:0];
        end else if (busy) begin
            if (!src_frz_q)
                rd_cur <= rd_cur + 1'b1;
            if (!dst_frz_q)
                wr_cur <= wr_cur + 1'b1;
        end
    end

    assign rf_rd_addr = rf_addr_t'(rd_cur);
    assign rf_wr_addr = rf_addr_t'(wr_cur);
    assign rf_copy    = busy;

endmodule

`default_nettype wire
